// ==== common/mecobo_settings.svh ====
// mecobo settings: pin count, fifo depths and host register map
`ifndef MECOBO_SETTINGS_SVH
`define MECOBO_SETTINGS_SVH

// number of pin controllers on the command bus
`define MECOBO_NUM_PINS 8

// fifo depths, in entries
`define MECOBO_CMD_DEPTH 16
`define MECOBO_SAMPLE_DEPTH 16

// host register addresses, 8 bit
`define MECOBO_ADDR_TIME_LO 8'd0
`define MECOBO_ADDR_TIME_HI 8'd1
`define MECOBO_ADDR_PIN 8'd2
`define MECOBO_ADDR_OPCODE 8'd3
`define MECOBO_ADDR_VALUE 8'd4
`define MECOBO_ADDR_COMMIT 8'd5
`define MECOBO_ADDR_STATUS 8'd8
`define MECOBO_ADDR_SAMPLE 8'd9

`endif

// ==== common/cmd_pkg.sv ====
// command package: opcodes, queued command record and command bus record
package cmd_pkg;

  // opcodes carried by each command
  typedef enum logic [2:0] {
    op_set_mode   = 3'd0,
    op_set_period = 3'd1,
    op_set_duty   = 3'd2,
    op_sample     = 3'd3,
    op_reset_time = 3'd4
  } cmd_op_e;

  // one queued command, as assembled by the host port
  typedef struct packed {
    logic [31:0] exec_time;
    logic [3:0]  pin;
    cmd_op_e     op;
    logic [15:0] value;
  } cmd_t;

  // broadcast from the scheduler, one cycle strobe on en
  typedef struct packed {
    logic        en;
    logic [3:0]  pin;
    cmd_op_e     op;
    logic [15:0] value;
  } cmd_bus_t;

endpackage

// ==== common/pin_pkg.sv ====
// pin package: pin output modes and the sample word read by the host
package pin_pkg;

  // output mode of one pin controller
  typedef enum logic [1:0] {
    mode_low  = 2'd0,
    mode_high = 2'd1,
    mode_pwm  = 2'd2
  } pin_mode_e;

  // one sample, read by the host as a single 16 bit word
  typedef struct packed {
    // low 12 bits of global time at capture
    logic [11:0] stamp;
    logic [2:0]  pin;
    logic        level;
  } sample_t;

endpackage

// ==== hdl/cmd_fifo.sv ====
// command fifo: circular buffer with first-word-fall-through output
`timescale 1ns/1ns

module cmd_fifo #(
  parameter int DEPTH = 16,
  parameter type data_t = logic [15:0]
) (
  input  logic  sys_clk,
  input  logic  global_clock_reset,
  input  logic  push,
  input  data_t din,
  input  logic  pop,
  output data_t dout,
  output logic  valid,
  output logic  full,
  output logic  empty
);
  localparam int AW = $clog2(DEPTH);

  data_t          mem [DEPTH];
  logic [AW-1:0]  wr_ptr;
  logic [AW-1:0]  rd_ptr;
  logic [AW:0]    count;
  logic           do_push;
  logic           do_pop;

  // push while full and pop while empty are ignored
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign full  = (count == (AW+1)'(DEPTH));
  assign empty = (count == '0);
  assign valid = !empty;
  // head is visible without a pop
  assign dout  = mem[rd_ptr];

  always_ff @(posedge sys_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap at DEPTH, also for odd depths
      if (do_push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== host_bus/host_bus.sv ====
// host bus: register port that stages commands, reports status and pops samples
`timescale 1ns/1ns
`include "mecobo_settings.svh"

module host_bus (
  input  logic             sys_clk,
  input  logic             global_clock_reset,
  input  logic             host_cs,
  input  logic             host_wr,
  input  logic [7:0]       host_addr,
  input  logic [15:0]      host_wdata,
  output logic [15:0]      host_rdata,
  output logic             cmd_push,
  output cmd_pkg::cmd_t    cmd,
  input  logic             cmd_full,
  input  logic             cmd_empty,
  input  logic             sample_valid,
  input  pin_pkg::sample_t sample,
  input  logic             sample_overflow,
  output logic             sample_pop
);
  import cmd_pkg::*;

  // staging registers for the next command
  logic [15:0] time_lo;
  logic [15:0] time_hi;
  logic [3:0]  pin_q;
  cmd_op_e     op_q;
  logic [15:0] value_q;
  logic        cmd_overflow;
  logic        wr_access;
  logic        rd_access;

  assign wr_access = host_cs && host_wr;
  assign rd_access = host_cs && !host_wr;

  // command word straight from staging
  assign cmd = '{exec_time: {time_hi, time_lo}, pin: pin_q, op: op_q, value: value_q};

  // pop together with the registered read of the head
  assign sample_pop = rd_access && (host_addr == `MECOBO_ADDR_SAMPLE) && sample_valid;

  always_ff @(posedge sys_clk) begin
    if (wr_access) begin
      case (host_addr)
        `MECOBO_ADDR_TIME_LO: time_lo <= host_wdata;
        `MECOBO_ADDR_TIME_HI: time_hi <= host_wdata;
        `MECOBO_ADDR_PIN:     pin_q   <= host_wdata[3:0];
        `MECOBO_ADDR_OPCODE:  op_q    <= cmd_op_e'(host_wdata[2:0]);
        `MECOBO_ADDR_VALUE:   value_q <= host_wdata;
        default: ;
      endcase
    end
  end

  // push one cycle after commit, staging is stable by then
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      cmd_push     <= 1'b0;
      cmd_overflow <= 1'b0;
    end else begin
      cmd_push <= wr_access && (host_addr == `MECOBO_ADDR_COMMIT);
      // sticky, fifo drops this push
      if (cmd_push && cmd_full) begin
        cmd_overflow <= 1'b1;
      end
    end
  end

  // registered read data, valid the cycle after the access
  always_ff @(posedge sys_clk) begin
    if (rd_access) begin
      case (host_addr)
        `MECOBO_ADDR_TIME_LO: host_rdata <= time_lo;
        `MECOBO_ADDR_TIME_HI: host_rdata <= time_hi;
        `MECOBO_ADDR_PIN:     host_rdata <= {12'd0, pin_q};
        `MECOBO_ADDR_OPCODE:  host_rdata <= {13'd0, op_q};
        `MECOBO_ADDR_VALUE:   host_rdata <= value_q;
        `MECOBO_ADDR_STATUS:
          host_rdata <= {11'd0, sample_overflow, sample_valid, cmd_overflow, cmd_full, cmd_empty};
        // zero when nothing is queued
        `MECOBO_ADDR_SAMPLE:  host_rdata <= sample_valid ? sample : 16'd0;
        default:              host_rdata <= 16'd0;
      endcase
    end
  end

endmodule

// ==== scheduler/scheduler.sv ====
// scheduler: global time counter and timed release of commands onto the bus
`timescale 1ns/1ns

module scheduler (
  input  logic              sys_clk,
  input  logic              global_clock_reset,
  input  cmd_pkg::cmd_t     head,
  input  logic              head_valid,
  output logic              head_pop,
  output cmd_pkg::cmd_bus_t cmd_bus,
  output logic [31:0]       global_time
);
  import cmd_pkg::*;

  logic        bus_en;
  logic [3:0]  bus_pin;
  cmd_op_e     bus_op;
  logic [15:0] bus_value;
  logic        time_clear;

  // head is due once the counter has reached its time, late ones too
  assign head_pop = head_valid && (global_time >= head.exec_time);

  // handled here, never broadcast
  assign time_clear = head_pop && (head.op == op_reset_time);

  assign cmd_bus = '{en: bus_en, pin: bus_pin, op: bus_op, value: bus_value};

  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      global_time <= '0;
    end else if (time_clear) begin
      // zero from the next cycle
      global_time <= '0;
    end else begin
      global_time <= global_time + 32'd1;
    end
  end

  // strobe lands one cycle after the pop
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      bus_en <= 1'b0;
    end else begin
      bus_en <= head_pop && !time_clear;
    end
  end

  // bus payload, only meaningful with en
  always_ff @(posedge sys_clk) begin
    if (head_pop) begin
      bus_pin   <= head.pin;
      bus_op    <= head.op;
      bus_value <= head.value;
    end
  end

endmodule

// ==== pin_control/pin_control.sv ====
// pin control: one pin driven low, high or pwm from command bus settings
`timescale 1ns/1ns

module pin_control #(
  parameter int pin_index = 0
) (
  input  logic              sys_clk,
  input  logic              global_clock_reset,
  input  cmd_pkg::cmd_bus_t cmd_bus,
  output logic              pin
);
  import cmd_pkg::*;
  import pin_pkg::*;

  pin_mode_e   mode;
  logic [15:0] period;
  logic [15:0] duty;
  logic [15:0] pwm_cnt;
  logic        hit;

  // only commands addressed to this pin
  assign hit = cmd_bus.en && (cmd_bus.pin == 4'(pin_index));

  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      mode    <= mode_low;
      period  <= '0;
      duty    <= '0;
      pwm_cnt <= '0;
    end else begin
      // counter runs 0 .. period-1 in pwm mode only
      if (mode == mode_pwm) begin
        if (pwm_cnt + 16'd1 >= period) begin
          pwm_cnt <= '0;
        end else begin
          pwm_cnt <= pwm_cnt + 16'd1;
        end
      end else begin
        pwm_cnt <= '0;
      end

      // bus command wins over the counter step
      if (hit) begin
        case (cmd_bus.op)
          op_set_mode:   mode <= pin_mode_e'(cmd_bus.value[1:0]);
          op_set_period: begin
            period  <= cmd_bus.value;
            // restart the window
            pwm_cnt <= '0;
          end
          op_set_duty:   duty <= cmd_bus.value;
          default: ;
        endcase
      end
    end
  end

  // output follows the mode register, new mode shows the cycle after the strobe
  always_comb begin
    case (mode)
      mode_high: pin = 1'b1;
      mode_pwm:  pin = (pwm_cnt < duty);
      default:   pin = 1'b0;
    endcase
  end

endmodule

// ==== hdl/sample_collector.sv ====
// sample collector: timestamps pin levels on sample commands into a fifo
`timescale 1ns/1ns
`include "mecobo_settings.svh"

module sample_collector (
  input  logic                         sys_clk,
  input  logic                         global_clock_reset,
  input  cmd_pkg::cmd_bus_t            cmd_bus,
  input  logic [`MECOBO_NUM_PINS-1:0]  pins,
  input  logic [31:0]                  global_time,
  input  logic                         sample_pop,
  output pin_pkg::sample_t             sample,
  output logic                         sample_valid,
  output logic                         sample_overflow
);
  import cmd_pkg::*;
  import pin_pkg::*;

  sample_t capture;
  logic    capture_push;
  logic    fifo_full;

  // capture on the strobe cycle itself
  assign capture_push = cmd_bus.en && (cmd_bus.op == op_sample);

  assign capture = '{
    stamp: global_time[11:0],
    pin:   cmd_bus.pin[2:0],
    level: pins[cmd_bus.pin[2:0]]
  };

  // sample buffer, head shows one cycle after the push
  cmd_fifo #(
    .DEPTH  (`MECOBO_SAMPLE_DEPTH),
    .data_t (sample_t)
  ) i_sample_fifo (
    .sys_clk            (sys_clk),
    .global_clock_reset (global_clock_reset),
    .push               (capture_push),
    .din                (capture),
    .pop                (sample_pop),
    .dout               (sample),
    .valid              (sample_valid),
    .full               (fifo_full),
    .empty              ()
  );

  // sticky, the dropped sample is lost
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      sample_overflow <= 1'b0;
    end else if (capture_push && fifo_full) begin
      sample_overflow <= 1'b1;
    end
  end

endmodule

// ==== hdl/mecobo_core.sv ====
// mecobo core: host port, command queue, scheduler, pin bank and sampler
`timescale 1ns/1ns
`include "mecobo_settings.svh"

module mecobo_core (
  input  logic                        sys_clk,
  input  logic                        global_clock_reset,
  input  logic                        host_cs,
  input  logic                        host_wr,
  input  logic [7:0]                  host_addr,
  input  logic [15:0]                 host_wdata,
  output logic [15:0]                 host_rdata,
  output logic [`MECOBO_NUM_PINS-1:0] pins
);
  import cmd_pkg::*;
  import pin_pkg::*;

  // host to command fifo
  cmd_t        cmd_in;
  logic        cmd_push;
  logic        cmd_full;
  logic        cmd_empty;
  // command fifo to scheduler
  cmd_t        cmd_head;
  logic        cmd_valid;
  logic        cmd_pop;
  // scheduler broadcast
  cmd_bus_t    cmd_bus;
  logic [31:0] global_time;
  // sampler to host
  sample_t     sample;
  logic        sample_valid;
  logic        sample_pop;
  logic        sample_overflow;

  host_bus i_host_bus (
    .sys_clk            (sys_clk),
    .global_clock_reset (global_clock_reset),
    .host_cs            (host_cs),
    .host_wr            (host_wr),
    .host_addr          (host_addr),
    .host_wdata         (host_wdata),
    .host_rdata         (host_rdata),
    .cmd_push           (cmd_push),
    .cmd                (cmd_in),
    .cmd_full           (cmd_full),
    .cmd_empty          (cmd_empty),
    .sample_valid       (sample_valid),
    .sample             (sample),
    .sample_overflow    (sample_overflow),
    .sample_pop         (sample_pop)
  );

  cmd_fifo #(
    .DEPTH  (`MECOBO_CMD_DEPTH),
    .data_t (cmd_t)
  ) i_cmd_fifo (
    .sys_clk            (sys_clk),
    .global_clock_reset (global_clock_reset),
    .push               (cmd_push),
    .din                (cmd_in),
    .pop                (cmd_pop),
    .dout               (cmd_head),
    .valid              (cmd_valid),
    .full               (cmd_full),
    .empty              (cmd_empty)
  );

  scheduler i_scheduler (
    .sys_clk            (sys_clk),
    .global_clock_reset (global_clock_reset),
    .head               (cmd_head),
    .head_valid         (cmd_valid),
    .head_pop           (cmd_pop),
    .cmd_bus            (cmd_bus),
    .global_time        (global_time)
  );

  // one controller per pin, all on the shared bus
  for (genvar i = 0; i < `MECOBO_NUM_PINS; i++) begin : g_pin
    pin_control #(
      .pin_index (i)
    ) i_pin_control (
      .sys_clk            (sys_clk),
      .global_clock_reset (global_clock_reset),
      .cmd_bus            (cmd_bus),
      .pin                (pins[i])
    );
  end

  sample_collector i_sample_collector (
    .sys_clk            (sys_clk),
    .global_clock_reset (global_clock_reset),
    .cmd_bus            (cmd_bus),
    .pins               (pins),
    .global_time        (global_time),
    .sample_pop         (sample_pop),
    .sample             (sample),
    .sample_valid       (sample_valid),
    .sample_overflow    (sample_overflow)
  );

endmodule

// ==== tests/mecobo_asserts.sv ====
// mecobo assertions: handshake, reset and pin level properties bound into the core
`timescale 1ns/1ns

module mecobo_asserts (
  input logic             sys_clk,
  input logic             global_clock_reset,
  input logic             cmd_push,
  input logic             cmd_full,
  input logic             cmd_pop,
  input logic             cmd_empty,
  input cmd_pkg::cmd_bus_t cmd_bus,
  input logic [7:0]       pins
);

  // a push into a full fifo is dropped, so it stays full
  a_no_push_full: assert property (@(posedge sys_clk) disable iff (global_clock_reset)
    (cmd_push && cmd_full && !cmd_pop) |=> cmd_full)
    else $error("command fifo accepted a push while full");

  // scheduler pops only a valid head
  a_no_pop_empty: assert property (@(posedge sys_clk) disable iff (global_clock_reset)
    cmd_pop |-> !cmd_empty)
    else $error("command fifo popped while empty");

  // bus quiet through reset
  a_bus_idle_reset: assert property (@(posedge sys_clk)
    global_clock_reset |=> !cmd_bus.en)
    else $error("command bus strobed during reset");

  a_pins_known: assert property (@(posedge sys_clk) disable iff (global_clock_reset)
    !$isunknown(pins))
    else $error("pin outputs unknown after reset");

endmodule

// ==== tests/mecobo_tb.sv ====
// mecobo testbench: clock, reset, core instance and a case driven checker
`timescale 1ns/1ns

module mecobo_checker (
  input  logic        sys_clk,
  input  logic        global_clock_reset,
  output logic        host_cs,
  output logic        host_wr,
  output logic [7:0]  host_addr,
  output logic [15:0] host_wdata,
  input  logic [15:0] host_rdata,
  input  logic [7:0]  pins,
  input  logic [31:0] global_time,
  output logic        done,
  output int          errors,
  output int          checks,
  output int          limit
);
  // parsed cases, one entry per operation
  byte         ops[$];
  logic [31:0] fa[$];
  logic [31:0] fb[$];
  logic [31:0] fc[$];

  // one clock, back to 1 ns after the edge
  task automatic step();
    @(posedge sys_clk);
    #1;
  endtask

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Error: time %0t signal %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic host_write(input logic [7:0] addr, input logic [15:0] data);
    host_cs    = 1'b1;
    host_wr    = 1'b1;
    host_addr  = addr;
    host_wdata = data;
    step();
    host_cs = 1'b0;
    host_wr = 1'b0;
  endtask

  // rdata is registered, so it is checked one edge later
  task automatic host_read(input logic [7:0] addr, input logic [15:0] exp,
                           input logic [15:0] mask);
    host_cs   = 1'b1;
    host_wr   = 1'b0;
    host_addr = addr;
    step();
    host_cs = 1'b0;
    compare($sformatf("host_rdata@%0h", addr), exp & mask, host_rdata & mask);
  endtask

  // step until the core clock reaches t, timeout guards a miss
  task automatic wait_time(input logic [31:0] t);
    while (global_time != t) begin
      step();
    end
  endtask

  // any period long stretch holds exactly duty high cycles, four in a row
  task automatic pwm_window(input int p, input int period, input int duty);
    int highs;
    repeat (4) begin
      highs = 0;
      repeat (period) begin
        highs += pins[p];
        step();
      end
      compare($sformatf("pins[%0d] high count", p), duty, highs);
    end
  endtask

  task automatic load_cases();
    int    fd;
    int    n;
    int    rep;
    byte   op;
    string line;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    rep   = 1;
    limit = 500;
    fd = $fopen("tests/mecobo_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the cases file tests/mecobo_cases.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      // skip blanks and comments
      if (n == 0 || line.len() < 2 || line[0] == "#") begin
        continue;
      end
      a = 0;
      b = 0;
      c = 0;
      n = $sscanf(line, "%c %h %h %h", op, a, b, c);
      if (op == "L") begin
        // repeat count for the next line
        rep = a;
        continue;
      end
      // waits of either kind feed the timeout
      if (op == "N" || op == "T") begin
        limit += 4 * a;
      end
      if (op == "M") begin
        limit += 4 * 4 * b;
      end
      repeat (rep) begin
        ops.push_back(op);
        fa.push_back(a);
        fb.push_back(b);
        fc.push_back(c);
      end
      limit += rep * 2;
      rep = 1;
    end
    $fclose(fd);
  endtask

  initial begin
    host_cs    = 1'b0;
    host_wr    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    done       = 1'b0;
    errors     = 0;
    checks     = 0;
    limit      = 0;
    load_cases();
    wait (!global_clock_reset);
    step();
    foreach (ops[i]) begin
      case (ops[i])
        "W": host_write(fa[i][7:0], fb[i][15:0]);
        "R": host_read(fa[i][7:0], fb[i][15:0], fc[i][15:0]);
        "N": repeat (fa[i]) step();
        "T": wait_time(fa[i]);
        "P": compare($sformatf("pins[%0d]", fa[i]), fb[i][0], pins[fa[i][2:0]]);
        "A": compare("pins", fa[i][7:0], pins);
        "M": pwm_window(fa[i], fb[i], fc[i]);
        default: begin
          errors++;
          $display("unknown operation in cases file at entry %0d", i);
        end
      endcase
    end
    done = 1'b1;
  end

endmodule

module mecobo_tb;
  logic        sys_clk;
  logic        global_clock_reset;
  logic        host_cs;
  logic        host_wr;
  logic [7:0]  host_addr;
  logic [15:0] host_wdata;
  logic [15:0] host_rdata;
  logic [7:0]  pins;
  logic        done;
  int          errors;
  int          checks;
  int          limit;
  int          cycles;

  mecobo_core i_dut (
    .sys_clk            (sys_clk),
    .global_clock_reset (global_clock_reset),
    .host_cs            (host_cs),
    .host_wr            (host_wr),
    .host_addr          (host_addr),
    .host_wdata         (host_wdata),
    .host_rdata         (host_rdata),
    .pins               (pins)
  );

  mecobo_checker i_checker (
    .sys_clk            (sys_clk),
    .global_clock_reset (global_clock_reset),
    .host_cs            (host_cs),
    .host_wr            (host_wr),
    .host_addr          (host_addr),
    .host_wdata         (host_wdata),
    .host_rdata         (host_rdata),
    .pins               (pins),
    .global_time        (i_dut.i_scheduler.global_time),
    .done               (done),
    .errors             (errors),
    .checks             (checks),
    .limit              (limit)
  );

  bind mecobo_core mecobo_asserts i_asserts (
    .sys_clk            (sys_clk),
    .global_clock_reset (global_clock_reset),
    .cmd_push           (cmd_push),
    .cmd_full           (cmd_full),
    .cmd_pop            (cmd_pop),
    .cmd_empty          (cmd_empty),
    .cmd_bus            (cmd_bus),
    .pins               (pins)
  );

  // 40 ns clock
  initial begin
    sys_clk = 1'b0;
    forever #20 sys_clk = ~sys_clk;
  end

  initial begin
    global_clock_reset = 1'b1;
    cycles             = 0;
    repeat (5) @(posedge sys_clk);
    #1;
    global_clock_reset = 1'b0;
  end

  // limit comes from the parsed cases
  always @(posedge sys_clk) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles >= limit && !done) begin
      $display("timeout: cases did not complete within %0d cycles", limit);
      $display("Test FAILED");
      $finish;
    end
  end

  initial begin
    wait (done);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== tests/mecobo_cases.txt ====
# op fields in hex: W addr data | R addr expect mask | N cycles | T core_time
# P pin level | A pin_vector | M pin period duty | L count (repeats next line)
R 8 1 ffff
A 0
R 9 0 ffff
W 0 80
W 1 0
W 2 1
W 3 0
W 4 1
W 5 1
T 81
P 1 0
T 82
P 1 1
W 0 a0
W 4 0
W 5 1
T a1
P 1 1
T a2
P 1 0
W 2 2
W 0 c0
W 3 1
W 4 5
W 5 1
W 0 c1
W 3 2
W 4 2
W 5 1
W 0 c2
W 3 0
W 4 2
W 5 1
T c8
M 2 5 2
W 2 3
W 0 100
W 3 0
W 4 1
W 5 1
W 0 110
W 3 3
W 5 1
W 2 1
W 0 111
W 5 1
T 118
R 8 9 ffff
R 9 1117 ffff
R 9 1122 ffff
R 9 0 ffff
W 0 130
W 3 4
W 5 1
W 0 40
W 3 3
W 2 3
W 5 1
T 50
W 0 5
W 5 1
N 8
R 9 417 ffff
R 9 7 f
R 9 0 ffff
L 11
W 5 1
N 10
R 8 19 ffff
L 10
R 9 7 f
R 9 0 ffff
R 8 11 ffff
W 1 ffff
L 11
W 5 1
N 4
R 8 16 ffff

// ==== files.f ====
+incdir+common
common/cmd_pkg.sv
common/pin_pkg.sv
hdl/cmd_fifo.sv
host_bus/host_bus.sv
scheduler/scheduler.sv
pin_control/pin_control.sv
hdl/sample_collector.sv
hdl/mecobo_core.sv
tests/mecobo_asserts.sv
tests/mecobo_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the mecobo testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module mecobo_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/Vmecobo_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
  exit 0
fi
exit 1
